// File: Bender.yml
package:
  name: shot_mover

sources:
  - include_dirs:
      - common
    files:
      - common/shot_pkg.sv
      - logic/shot_table.sv
      - logic/shot_step.sv
      - shot_ctrl/shot_move_ctrl.sv
      - logic/shot_mover_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - dv/shot_mover_tb.sv

// File: common/shot_cfg.svh
/* Shot mover configuration
   Slot count, coordinate width, field borders and step size */

`ifndef SHOT_CFG_SVH
`define SHOT_CFG_SVH

// Table size
`define SHOT_SLOTS      8

// One screen coordinate
`define SHOT_COORD_W    8

// Inclusive field borders, both axes start at 0
`define SHOT_X_MAX      159
`define SHOT_Y_MAX      119

// Distance covered in one pass
`define SHOT_STEP       1

`endif

// File: common/shot_pkg.sv
/* Shot mover types
   Coordinate, slot index, direction, shot record and control states */

`default_nettype none

`include "shot_cfg.svh"

package shot_pkg;

        typedef logic [`SHOT_COORD_W-1:0]        coord_t;
        typedef logic [$clog2(`SHOT_SLOTS)-1:0]  slot_t;

        typedef enum logic [1:0] {
                dir_right = 2'd0,       // +X
                dir_left  = 2'd1,       // -X
                dir_down  = 2'd2,       // +Y
                dir_up    = 2'd3        // -Y
        } shot_dir_t;

        typedef struct packed {
                logic      loaded;
                shot_dir_t dir;
                coord_t    x;
                coord_t    y;
        } shot_t;

        typedef enum logic [3:0] {
                st_idle, st_clear_count, st_check_loaded, st_check_edge,
                st_unload, st_save_unload, st_pick_dir,
                st_step_x_up, st_step_x_down, st_step_y_up, st_step_y_down,
                st_save_pos, st_next_slot, st_settle, st_done
        } move_state_t;

endpackage

`default_nettype wire

// File: dv/shot_cases.txt
# F slot dir x y | C slot loaded dir x y | M runs one move pass
# dir: 0 right, 1 left, 2 down, 3 up
F 0 0 50 60
F 1 1 50 60
F 2 2 50 60
F 3 3 50 60
C 2 1 2 50 60
M
C 0 1 0 51 60
C 1 1 1 49 60
C 2 1 2 50 61
C 3 1 3 50 59
C 4 0 0 0 0
F 0 0 159 10
F 1 1 0 20
F 2 2 30 119
F 3 3 40 0
F 4 0 0 70
F 5 3 80 119
M
C 0 0 0 159 10
C 1 0 1 0 20
C 2 0 2 30 119
C 3 0 3 40 0
C 4 1 0 1 70
C 5 1 3 80 118
C 6 0 0 0 0
M
C 4 1 0 2 70
C 2 0 2 30 119

// File: dv/shot_mover_tb.sv
/* Shot mover testbench
   Replays the case file, then checks random passes against a reference model */

`timescale 1ns/1ns
`default_nettype none

`include "shot_cfg.svh"

module shot_mover_tb;
        import shot_pkg::*;

        localparam int num_passes = 20;
        localparam int case_lines = 30;

        logic        clock = 1'b0;
        logic        reset;
        logic        fire;
        slot_t       fire_slot;
        shot_t       fire_shot;
        logic        move;
        logic        move_done;
        slot_t       peek_slot;
        shot_t       peek_shot;
        logic [31:0] rng_state = 32'hf3e8ed43;

        shot_mover_top dut_i (
                .clock     (clock),
                .reset     (reset),
                .fire      (fire),
                .fire_slot (fire_slot),
                .fire_shot (fire_shot),
                .move      (move),
                .move_done (move_done),
                .peek_slot (peek_slot),
                .peek_shot (peek_shot)
        );

        always #4 clock = ~clock;               // 8 ns period

        task automatic abort_run(input string why);
                $display("%s", why);
                $display("SOME TESTS FAILED");
                $fatal(1, "run aborted");
        endtask

        task automatic check_shot(input string name, input shot_t expected, input shot_t actual);
                if (actual !== expected) begin
                        $display("Fail at %0t ns: %s expected %h, got %h",
                                 $time, name, expected, actual);
                        $display("SOME TESTS FAILED");
                        $fatal(1, "shot record mismatch");
                end
        endtask

        task automatic check_done(input bit expected, input bit actual);
                if (actual !== expected) begin
                        $display("Fail at %0t ns: move_done expected %b, got %b",
                                 $time, expected, actual);
                        $display("SOME TESTS FAILED");
                        $fatal(1, "move_done mismatch");
                end
        endtask

        task automatic after_edge();
                @(posedge clock);
                #1;                             // Inputs change 1 ns after the edge
        endtask

        task automatic load_slot(input slot_t slot, input shot_t shot);
                after_edge();
                fire      = 1'b1;
                fire_slot = slot;
                fire_shot = shot;
                after_edge();
                fire      = 1'b0;
        endtask

        task automatic peek_check(input slot_t slot, input shot_t expected);
                after_edge();
                peek_slot = slot;
                @(negedge clock);
                check_shot($sformatf("peek_shot[%0d]", slot), expected, peek_shot);
        endtask

        // One pass, optionally with a stray move pulse while it runs
        task automatic run_pass(input bit second_move);
                after_edge();
                move = 1'b1;
                after_edge();
                move = 1'b0;
                if (second_move) begin
                        repeat (12) begin       // First slot is written back by now
                                @(negedge clock);
                                check_done(1'b0, move_done);
                        end
                        after_edge();
                        move = 1'b1;
                        after_edge();
                        move = 1'b0;
                end
                while (!move_done)
                        @(negedge clock);
                @(negedge clock);
                check_done(1'b0, move_done);    // Pulse lasts one cycle
                if (second_move) begin
                        repeat (64) begin       // Longer than any pass
                                @(negedge clock);
                                check_done(1'b0, move_done);
                        end
                end
        endtask

        function automatic logic [31:0] lcg_next(input logic [31:0] s);
                return s * 32'd1664525 + 32'd1013904223;
        endfunction

        task automatic new_random_shot(output shot_t shot);
                rng_state   = lcg_next(rng_state);
                shot.x      = coord_t'((rng_state >> 8) % (`SHOT_X_MAX + 1));
                rng_state   = lcg_next(rng_state);
                shot.y      = coord_t'((rng_state >> 8) % (`SHOT_Y_MAX + 1));
                rng_state   = lcg_next(rng_state);
                shot.dir    = shot_dir_t'(rng_state[31:30]);
                shot.loaded = 1'b1;
        endtask

        // Reference rule: unload on the heading border, else one step
        function automatic shot_t model_step(input shot_t s);
                shot_t r;
                r = s;
                if (s.loaded) begin
                        case (s.dir)
                                dir_right: begin
                                        if (s.x == `SHOT_X_MAX)
                                                r.loaded = 1'b0;
                                        else
                                                r.x = s.x + `SHOT_STEP;
                                end
                                dir_left: begin
                                        if (s.x == 0)
                                                r.loaded = 1'b0;
                                        else
                                                r.x = s.x - `SHOT_STEP;
                                end
                                dir_down: begin
                                        if (s.y == `SHOT_Y_MAX)
                                                r.loaded = 1'b0;
                                        else
                                                r.y = s.y + `SHOT_STEP;
                                end
                                default: begin
                                        if (s.y == 0)
                                                r.loaded = 1'b0;
                                        else
                                                r.y = s.y - `SHOT_STEP;
                                end
                        endcase
                end
                return r;
        endfunction

        // Rest of an F line: slot, dir, x, y
        task automatic fire_from_file(input int fd);
                int    cnt;
                int    slot;
                int    dir;
                int    x;
                int    y;
                shot_t shot;
                cnt = $fscanf(fd, "%d %d %d %d", slot, dir, x, y);
                if (cnt != 4) begin
                        abort_run("A fire line in the case file is malformed");
                end else begin
                        shot.loaded = 1'b1;
                        shot.dir    = shot_dir_t'(dir);
                        shot.x      = coord_t'(x);
                        shot.y      = coord_t'(y);
                        load_slot(slot_t'(slot), shot);
                end
        endtask

        // Rest of a C line: slot, loaded, dir, x, y
        task automatic check_from_file(input int fd);
                int    cnt;
                int    slot;
                int    loaded;
                int    dir;
                int    x;
                int    y;
                shot_t shot;
                cnt = $fscanf(fd, "%d %d %d %d %d", slot, loaded, dir, x, y);
                if (cnt != 5) begin
                        abort_run("A check line in the case file is malformed");
                end else begin
                        shot.loaded = loaded[0];
                        shot.dir    = shot_dir_t'(dir);
                        shot.x      = coord_t'(x);
                        shot.y      = coord_t'(y);
                        peek_check(slot_t'(slot), shot);
                end
        endtask

        task automatic replay_cases();
                int          fd;
                int          cnt;
                int          c;
                logic [7:0]  kind;
                fd = $fopen("dv/shot_cases.txt", "r");
                if (fd == 0) begin
                        abort_run("Could not open the case file dv/shot_cases.txt");
                end else begin
                        cnt = $fscanf(fd, " %c", kind);
                        while (cnt == 1) begin
                                case (kind)
                                        "#": begin      // Skip the rest of a comment line
                                                c = $fgetc(fd);
                                                while (c != 10 && c != -1)
                                                        c = $fgetc(fd);
                                        end
                                        "F":     fire_from_file(fd);
                                        "M":     run_pass(1'b0);
                                        "C":     check_from_file(fd);
                                        default:
                                                abort_run("Unknown record type in the case file");
                                endcase
                                cnt = $fscanf(fd, " %c", kind);
                        end
                        $fclose(fd);
                end
        endtask

        task automatic random_phase();
                shot_t model [`SHOT_SLOTS];
                for (int p = 0; p < num_passes; p++) begin
                        for (int s = 0; s < `SHOT_SLOTS; s++) begin
                                // Refill spent slots every other pass only
                                if (p == 0 || (p % 2 == 0 && !model[s].loaded)) begin
                                        new_random_shot(model[s]);
                                        load_slot(slot_t'(s), model[s]);
                                end
                        end
                        run_pass(p % 4 == 3);
                        for (int s = 0; s < `SHOT_SLOTS; s++) begin
                                model[s] = model_step(model[s]);
                                peek_check(slot_t'(s), model[s]);
                        end
                end
        endtask

        initial begin
                #((num_passes + case_lines) * `SHOT_SLOTS * 7 * 8 + 20000);
                abort_run("Timeout: a move pass never finished");
        end

        initial begin
                reset     = 1'b1;
                fire      = 1'b0;
                fire_slot = '0;
                fire_shot = '0;
                move      = 1'b0;
                peek_slot = '0;
                repeat (5) @(posedge clock);
                #1 reset = 1'b0;
                for (int s = 0; s < `SHOT_SLOTS; s++)
                        peek_check(slot_t'(s), '0);     // All slots empty after reset
                repeat (10) begin
                        @(negedge clock);
                        check_done(1'b0, move_done);
                end
                replay_cases();
                random_phase();
                $display("ALL TESTS PASSED");
                $finish;
        end

endmodule

`default_nettype wire

// File: logic/shot_mover_top.sv
/* Shot mover top level
   Control unit, shot table and step datapath */

`timescale 1ns/1ns
`default_nettype none

module shot_mover_top (
        input  logic            clock,
        input  logic            reset,
        input  logic            fire,
        input  shot_pkg::slot_t fire_slot,
        input  shot_pkg::shot_t fire_shot,
        input  logic            move,
        output logic            move_done,
        input  shot_pkg::slot_t peek_slot,
        output shot_pkg::shot_t peek_shot
);
        import shot_pkg::*;

        slot_t  cur_slot;
        shot_t  cur_shot;
        shot_t  wr_shot;
        logic   wr_en;
        coord_t next_x;
        coord_t next_y;
        logic   at_x_max;
        logic   at_x_min;
        logic   at_y_max;
        logic   at_y_min;

        shot_move_ctrl ctrl_i (
                .clock     (clock),
                .reset     (reset),
                .move      (move),
                .cur_shot  (cur_shot),
                .next_x    (next_x),
                .next_y    (next_y),
                .at_x_max  (at_x_max),
                .at_x_min  (at_x_min),
                .at_y_max  (at_y_max),
                .at_y_min  (at_y_min),
                .cur_slot  (cur_slot),
                .wr_en     (wr_en),
                .wr_shot   (wr_shot),
                .move_done (move_done)
        );

        shot_table table_i (
                .clock     (clock),
                .reset     (reset),
                .fire      (fire),
                .fire_slot (fire_slot),
                .fire_shot (fire_shot),
                .wr_en     (wr_en),
                .cur_slot  (cur_slot),
                .wr_shot   (wr_shot),
                .peek_slot (peek_slot),
                .cur_shot  (cur_shot),
                .peek_shot (peek_shot)
        );

        shot_step step_i (
                .cur_shot (cur_shot),
                .next_x   (next_x),
                .next_y   (next_y),
                .at_x_max (at_x_max),
                .at_x_min (at_x_min),
                .at_y_max (at_y_max),
                .at_y_min (at_y_min)
        );

endmodule

`default_nettype wire

// File: logic/shot_step.sv
/* Shot step datapath
   Next coordinate along the shot direction and field border flags */

`timescale 1ns/1ns
`default_nettype none

`include "shot_cfg.svh"

module shot_step (
        input  shot_pkg::shot_t  cur_shot,
        output shot_pkg::coord_t next_x,
        output shot_pkg::coord_t next_y,
        output logic             at_x_max,
        output logic             at_x_min,
        output logic             at_y_max,
        output logic             at_y_min
);
        import shot_pkg::*;

        localparam coord_t step  = coord_t'(`SHOT_STEP);
        localparam coord_t x_max = coord_t'(`SHOT_X_MAX);
        localparam coord_t y_max = coord_t'(`SHOT_Y_MAX);

        // Only the axis of travel changes
        always_comb begin
                next_x = cur_shot.x;
                next_y = cur_shot.y;
                case (cur_shot.dir)
                        dir_right: next_x = cur_shot.x + step;
                        dir_left:  next_x = cur_shot.x - step;
                        dir_down:  next_y = cur_shot.y + step;
                        dir_up:    next_y = cur_shot.y - step;
                        default: ;
                endcase
        end

        assign at_x_max = (cur_shot.x >= x_max);
        assign at_x_min = (cur_shot.x == '0);
        assign at_y_max = (cur_shot.y >= y_max);
        assign at_y_min = (cur_shot.y == '0);

endmodule

`default_nettype wire

// File: logic/shot_table.sv
/* Shot table
   Register file of shot records with fire and control write ports */

`timescale 1ns/1ns
`default_nettype none

`include "shot_cfg.svh"

module shot_table (
        input  logic            clock,
        input  logic            reset,
        input  logic            fire,           // Fire write strobe
        input  shot_pkg::slot_t fire_slot,
        input  shot_pkg::shot_t fire_shot,
        input  logic            wr_en,          // Control write strobe
        input  shot_pkg::slot_t cur_slot,
        input  shot_pkg::shot_t wr_shot,
        input  shot_pkg::slot_t peek_slot,
        output shot_pkg::shot_t cur_shot,
        output shot_pkg::shot_t peek_shot
);
        import shot_pkg::*;

        shot_t shots [`SHOT_SLOTS];

        always_ff @(posedge clock or posedge reset) begin
                if (reset) begin
                        shots <= '{default: '0};        // All slots unloaded
                end else if (wr_en) begin
                        shots[cur_slot] <= wr_shot;     // Control port has priority
                end else if (fire) begin
                        shots[fire_slot] <= fire_shot;
                end
        end

        assign cur_shot  = shots[cur_slot];
        assign peek_shot = shots[peek_slot];

        // Fire is only legal while the control unit sits idle
        a_no_write_clash: assert property (@(posedge clock) disable iff (reset)
                !(fire && wr_en));

endmodule

`default_nettype wire

// File: shot_ctrl/shot_move_ctrl.sv
/* Shot move control unit
   Moore FSM that walks every slot, unloads shots at their edge and steps the rest */

`timescale 1ns/1ns
`default_nettype none

`include "shot_cfg.svh"

module shot_move_ctrl (
        input  logic             clock,
        input  logic             reset,
        input  logic             move,          // Starts one pass
        input  shot_pkg::shot_t  cur_shot,
        input  shot_pkg::coord_t next_x,
        input  shot_pkg::coord_t next_y,
        input  logic             at_x_max,
        input  logic             at_x_min,
        input  logic             at_y_max,
        input  logic             at_y_min,
        output shot_pkg::slot_t  cur_slot,
        output logic             wr_en,
        output shot_pkg::shot_t  wr_shot,
        output logic             move_done
);
        import shot_pkg::*;

        localparam slot_t last_slot_idx = slot_t'(`SHOT_SLOTS - 1);

        move_state_t state, state_next;
        slot_t       slot_cnt;
        logic        live;              // Loaded flag of the visited slot
        logic        edge_hit;          // Shot sits on the border it heads to
        logic        last_slot;
        shot_t       hold;              // Record to be written back

        assign last_slot = (slot_cnt == last_slot_idx);

        always_ff @(posedge clock or posedge reset) begin
                if (reset)
                        state <= st_idle;
                else
                        state <= state_next;
        end

        // Slot counter, wraps after the last slot
        always_ff @(posedge clock or posedge reset) begin
                if (reset)
                        slot_cnt <= '0;
                else if (state == st_clear_count)
                        slot_cnt <= '0;
                else if (state == st_next_slot || state == st_save_unload)
                        slot_cnt <= slot_cnt + 1'b1;
        end

        always_ff @(posedge clock or posedge reset) begin
                if (reset)
                        live <= 1'b0;
                else if (state == st_check_loaded)
                        live <= cur_shot.loaded;
        end

        always_ff @(posedge clock) begin
                case (state)
                        st_unload: begin
                                hold        <= cur_shot;
                                hold.loaded <= 1'b0;    // Shot leaves the field
                        end
                        st_pick_dir:                    hold   <= cur_shot;
                        st_step_x_up, st_step_x_down:   hold.x <= next_x;
                        st_step_y_up, st_step_y_down:   hold.y <= next_y;
                        default: ;
                endcase
        end

        // Border in the direction of travel
        always_comb begin
                case (cur_shot.dir)
                        dir_right: edge_hit = at_x_max;
                        dir_left:  edge_hit = at_x_min;
                        dir_down:  edge_hit = at_y_max;
                        default:   edge_hit = at_y_min;
                endcase
        end

        always_comb begin
                case (state)
                        st_idle:         state_next = move ? st_clear_count : st_idle;
                        st_clear_count:  state_next = st_check_loaded;
                        st_check_loaded: state_next = st_check_edge;
                        st_check_edge: begin
                                if (!live)
                                        state_next = last_slot ? st_done : st_next_slot;
                                else if (edge_hit)
                                        state_next = st_unload;
                                else
                                        state_next = st_pick_dir;
                        end
                        st_unload:       state_next = st_save_unload;
                        st_save_unload:  state_next = last_slot ? st_done : st_settle;
                        st_pick_dir: begin
                                case (cur_shot.dir)
                                        dir_right: state_next = st_step_x_up;
                                        dir_left:  state_next = st_step_x_down;
                                        dir_down:  state_next = st_step_y_up;
                                        default:   state_next = st_step_y_down;
                                endcase
                        end
                        st_step_x_up,
                        st_step_x_down,
                        st_step_y_up,
                        st_step_y_down:  state_next = st_save_pos;
                        st_save_pos:     state_next = last_slot ? st_done : st_next_slot;
                        st_next_slot:    state_next = st_settle;
                        st_settle:       state_next = st_check_loaded;
                        st_done:         state_next = st_idle;
                        default:         state_next = st_idle;
                endcase
        end

        // Moore outputs
        assign cur_slot  = slot_cnt;
        assign wr_en     = (state == st_save_unload) || (state == st_save_pos);
        assign wr_shot   = hold;
        assign move_done = (state == st_done);

        a_done_single: assert property (@(posedge clock) disable iff (reset)
                move_done |=> !move_done);

        // Table still holds the old record during the write cycle
        a_write_loaded: assert property (@(posedge clock) disable iff (reset)
                $rose(wr_en) |-> cur_shot.loaded);

endmodule

`default_nettype wire

// File: shot_mover_top.f
+incdir+common
common/shot_pkg.sv
logic/shot_table.sv
logic/shot_step.sv
shot_ctrl/shot_move_ctrl.sv
logic/shot_mover_top.sv
dv/shot_mover_tb.sv
